//--- rtl/shift_alu_pkg.sv
`default_nettype none

package shift_alu_pkg;

	localparam int WORD_W     = 16;             // Datapath width
	localparam int FIFO_DEPTH = 4;              // Command buffer entries
	localparam int TAG_W      = 4;              // Sequence tag, wraps at 16
	localparam int SHAMT_W    = $clog2(WORD_W); // Shift amount 0..15
	localparam int PTR_W      = $clog2(FIFO_DEPTH);

	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [SHAMT_W-1:0] shamt_t;
	typedef logic [TAG_W-1:0]   tag_t;

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB, // a + ~b + 1
		OP_SHL,
		OP_SHR
	} alu_op_t;

	// Fill source for the bits shifted in
	typedef enum logic [1:0] {
		SH_LOGIC,
		SH_ARITH,
		SH_DOUBLE, // Fill taken from operand b
		SH_CYCLIC
	} shift_kind_t;

	typedef struct packed {
		alu_op_t     op;
		shift_kind_t kind;
		shamt_t      shamt;
		word_t       a;
		word_t       b;
	} cmd_t;

	typedef struct packed {
		tag_t tag;
		cmd_t cmd;
	} tagged_cmd_t;

	typedef struct packed {
		tag_t  tag;
		word_t value;
		logic  carry; // Always 0 for shifts
	} result_t;

	// Exec unit states, result handshake master
	typedef enum logic [1:0] {
		EX_IDLE,
		EX_REQ,
		EX_WAIT_LOW
	} fifo_state_t;

endpackage

`default_nettype wire

//--- rtl/cla_adder.sv
`timescale 1ns/100ps
`default_nettype none

module cla_adder #(
	parameter int group_size = 4,
	parameter int width      = shift_alu_pkg::WORD_W
) (
	input  wire              carry_in,
	input  wire [width-1:0]  a,
	input  wire [width-1:0]  b,
	output logic [width-1:0] sum,
	output logic             prop,     // Whole block propagates
	output logic             gen,      // Whole block generates
	output logic             carry_out
);

	// Split into group_size children, or single bits at the leaf level
	localparam int groups      = (width > group_size) ? group_size : width;
	localparam int child_width = width / groups;

	logic [groups-1:0] pp;     // Child propagate
	logic [groups-1:0] pg;     // Child generate
	logic [groups:0]   c;      // Carry into each child
	logic [groups:0]   pp_ext; // Padded for the top group term
	logic [groups-1:0] gterm;

	assign c[0]      = carry_in;
	assign carry_out = c[groups];
	assign prop      = &pp;
	assign pp_ext    = {1'b1, pp};

	if (width > group_size) begin : g_tree
		for (genvar i = 0; i < groups; i++) begin : g_child
			cla_adder #(.group_size(group_size), .width(child_width)) child_inst (
				.carry_in (c[i]),
				.a        (a[i*child_width +: child_width]),
				.b        (b[i*child_width +: child_width]),
				.sum      (sum[i*child_width +: child_width]),
				.prop     (pp[i]),
				.gen      (pg[i]),
				.carry_out() // Carries come from this level's lookahead
			);
		end
	end else begin : g_leaf
		assign pp  = a ^ b;
		assign pg  = a & b;
		assign sum = pp ^ c[groups-1:0];
	end

	// Lookahead carry into group i+1, no ripple through the children
	for (genvar i = 0; i < groups; i++) begin : g_carry
		logic [i+1:0] terms;
		assign terms[0]   = carry_in & (&pp[i:0]);
		assign terms[i+1] = pg[i];
		for (genvar j = 0; j < i; j++) begin : g_term
			assign terms[j+1] = pg[j] & (&pp[i:j+1]);
		end
		assign c[i+1]   = |terms;
		assign gterm[i] = pg[i] & (&pp_ext[groups:i+1]); // Survives all upper groups
	end

	assign gen = |gterm;

endmodule

`default_nettype wire

//--- rtl/poly_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module poly_shifter (
	input  wire shift_alu_pkg::word_t       data,
	input  wire shift_alu_pkg::word_t       fill,  // Second word for double shifts
	input  wire shift_alu_pkg::shamt_t      shamt,
	input  wire shift_alu_pkg::shift_kind_t kind,
	input  wire                             left,
	output shift_alu_pkg::word_t            result
);

	shift_alu_pkg::word_t fill_word; // Source of the bits shifted in

	// Every possible shift, picked by shamt afterwards
	shift_alu_pkg::word_t [shift_alu_pkg::WORD_W-1:0] shr_words;
	shift_alu_pkg::word_t [shift_alu_pkg::WORD_W-1:0] shl_words;

	always_comb begin
		case (kind)
			shift_alu_pkg::SH_LOGIC:  fill_word = '0;
			shift_alu_pkg::SH_ARITH: begin
				if (left)
					fill_word = '0; // Same as logic going left
				else
					fill_word = {shift_alu_pkg::WORD_W{data[shift_alu_pkg::WORD_W-1]}};
			end
			shift_alu_pkg::SH_DOUBLE: fill_word = fill;
			default:                  fill_word = data; // Cyclic, wrap own bits
		endcase
	end

	assign shr_words[0] = data;
	assign shl_words[0] = data;

	for (genvar i = 1; i < shift_alu_pkg::WORD_W; i++) begin : g_shift
		// Right: low fill bits enter at the top
		assign shr_words[i] = {
			fill_word[i-1:0],
			data[shift_alu_pkg::WORD_W-1:i]
		};
		// Left: high fill bits enter at the bottom
		assign shl_words[i] = {
			data[shift_alu_pkg::WORD_W-1-i:0],
			fill_word[shift_alu_pkg::WORD_W-1:shift_alu_pkg::WORD_W-i]
		};
	end

	assign result = left ? shl_words[shamt] : shr_words[shamt];

endmodule

`default_nettype wire

//--- rtl/cmd_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_fifo (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             wr_en,
	input  wire shift_alu_pkg::tagged_cmd_t wr_data,
	output logic                            full,
	input  wire                             rd_en,
	output shift_alu_pkg::tagged_cmd_t      rd_data, // Head entry
	output logic                            empty
);

	shift_alu_pkg::tagged_cmd_t mem [shift_alu_pkg::FIFO_DEPTH];

	logic [shift_alu_pkg::PTR_W-1:0] wr_ptr;
	logic [shift_alu_pkg::PTR_W-1:0] rd_ptr;
	logic [shift_alu_pkg::PTR_W:0]   count; // 0..FIFO_DEPTH
	logic                            do_wr;
	logic                            do_rd;

	assign full  = (count == shift_alu_pkg::FIFO_DEPTH);
	assign empty = (count == '0);

	// Writes when full and reads when empty are dropped
	assign do_wr = wr_en & ~full;
	assign do_rd = rd_en & ~empty;

	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two, wraps itself
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous read and write leaves count alone
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/cmd_intake.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_intake (
	input  wire                        clk,
	input  wire                        reset,
	input  wire shift_alu_pkg::cmd_t   cmd,
	input  wire                        cmd_req,
	output logic                       cmd_ack,
	output logic                       wr_en,
	output shift_alu_pkg::tagged_cmd_t wr_data,
	input  wire                        full
);

	shift_alu_pkg::tag_t tag; // Next tag to stamp
	logic                accept;

	// New request, not yet acked, and room in the buffer
	assign accept = cmd_req & ~cmd_ack & ~full;

	assign wr_en       = accept; // One write per handshake
	assign wr_data.tag = tag;
	assign wr_data.cmd = cmd;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cmd_ack <= 1'b0;
			tag     <= '0;
		end else begin
			if (accept) begin
				cmd_ack <= 1'b1;
				tag     <= tag + 1'b1; // Wraps at 16
			end else if (cmd_ack && !cmd_req) begin
				cmd_ack <= 1'b0; // Requester has let go
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
	input  wire                             clk,
	input  wire                             reset,
	output logic                            rd_en,
	input  wire shift_alu_pkg::tagged_cmd_t rd_data,
	input  wire                             empty,
	output shift_alu_pkg::result_t          res,
	output logic                            res_req,
	input  wire                             res_ack
);

	shift_alu_pkg::fifo_state_t state;
	shift_alu_pkg::cmd_t        cmd;      // Head command
	shift_alu_pkg::word_t       add_b;
	shift_alu_pkg::word_t       add_sum;
	shift_alu_pkg::word_t       shift_out;
	shift_alu_pkg::result_t     res_next;
	logic                       is_sub;
	logic                       add_carry;

	assign cmd    = rd_data.cmd;
	assign is_sub = (cmd.op == shift_alu_pkg::OP_SUB);
	assign add_b  = is_sub ? ~cmd.b : cmd.b; // Two's complement with carry in

	cla_adder #(.group_size(4), .width(shift_alu_pkg::WORD_W)) cla_adder_inst (
		.carry_in (is_sub),
		.a        (cmd.a),
		.b        (add_b),
		.sum      (add_sum),
		.prop     (),
		.gen      (),
		.carry_out(add_carry)
	);

	poly_shifter poly_shifter_inst (
		.data  (cmd.a),
		.fill  (cmd.b),
		.shamt (cmd.shamt),
		.kind  (cmd.kind),
		.left  (cmd.op == shift_alu_pkg::OP_SHL),
		.result(shift_out)
	);

	always_comb begin
		res_next.tag = rd_data.tag;
		case (cmd.op)
			shift_alu_pkg::OP_ADD, shift_alu_pkg::OP_SUB: begin
				res_next.value = add_sum;
				res_next.carry = add_carry; // 1 means no borrow on SUB
			end
			default: begin
				res_next.value = shift_out;
				res_next.carry = 1'b0;
			end
		endcase
	end

	// Pop only when idle, result lands on the same edge
	assign rd_en = (state == shift_alu_pkg::EX_IDLE) & ~empty;

	always_ff @(posedge clk) begin
		if (rd_en)
			res <= res_next; // Held through the whole handshake
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state   <= shift_alu_pkg::EX_IDLE;
			res_req <= 1'b0;
		end else begin
			case (state)
				shift_alu_pkg::EX_IDLE: begin
					if (!empty) begin
						res_req <= 1'b1;
						state   <= shift_alu_pkg::EX_REQ;
					end
				end
				shift_alu_pkg::EX_REQ: begin
					if (res_ack) begin
						res_req <= 1'b0;
						state   <= shift_alu_pkg::EX_WAIT_LOW;
					end
				end
				default: begin
					if (!res_ack)
						state <= shift_alu_pkg::EX_IDLE; // Ack released, free again
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/shift_alu_top.sv
`timescale 1ns/100ps
`default_nettype none

module shift_alu_top (
	input  wire                      clk,
	input  wire                      reset,
	input  wire shift_alu_pkg::cmd_t cmd,
	input  wire                      cmd_req,
	output logic                     cmd_ack,
	output shift_alu_pkg::result_t   res,
	output logic                     res_req,
	input  wire                      res_ack
);

	// Intake to buffer
	logic                       wr_en;
	shift_alu_pkg::tagged_cmd_t wr_data;
	logic                       full;

	// Buffer to execution
	logic                       rd_en;
	shift_alu_pkg::tagged_cmd_t rd_data;
	logic                       empty;

	cmd_intake cmd_intake_inst (
		.clk    (clk),
		.reset  (reset),
		.cmd    (cmd),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.wr_en  (wr_en),
		.wr_data(wr_data),
		.full   (full)    // Back-pressure onto the command port
	);

	cmd_fifo cmd_fifo_inst (
		.clk    (clk),
		.reset  (reset),
		.wr_en  (wr_en),
		.wr_data(wr_data),
		.full   (full),
		.rd_en  (rd_en),
		.rd_data(rd_data),
		.empty  (empty)
	);

	exec_unit exec_unit_inst (
		.clk    (clk),
		.reset  (reset),
		.rd_en  (rd_en),
		.rd_data(rd_data),
		.empty  (empty),
		.res    (res),
		.res_req(res_req),
		.res_ack(res_ack)
	);

endmodule

`default_nettype wire

//--- verif/shift_alu_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module shift_alu_assertions (
	input wire                         clk,
	input wire                         reset,
	input wire                         cmd_req,
	input wire                         cmd_ack,
	input wire shift_alu_pkg::result_t res,
	input wire                         res_req,
	input wire                         res_ack
);

	int fail_count = 0; // Failed checks so far

	// Ack only answers a live request
	a_ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(cmd_ack) |-> $past(cmd_req))
		else begin
			fail_count++;
			$error("cmd_ack rose while cmd_req was low");
		end

	a_res_stable: assert property (@(posedge clk) disable iff (reset)
		res_req && $past(res_req) |-> $stable(res)) // Held for the whole request
		else begin
			fail_count++;
			$error("res changed while res_req was high");
		end

	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		$fell(res_req) |-> $past(res_ack))
		else begin
			fail_count++;
			$error("res_req fell before res_ack was high");
		end

endmodule

bind shift_alu_top shift_alu_assertions shift_alu_assertions_inst (
	.clk, .reset, .cmd_req, .cmd_ack, .res, .res_req, .res_ack
);

`default_nettype wire

//--- verif/shift_alu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module shift_alu_tb;

	localparam int num_cmds    = 248;                            // All tests together
	localparam int reset_ns    = 16 * 8;
	localparam int watchdog_ns = num_cmds * 200 + 2 * reset_ns; // Two resets in the run

	logic                   clk;
	logic                   reset;
	shift_alu_pkg::cmd_t    cmd;
	logic                   cmd_req;
	logic                   cmd_ack;
	shift_alu_pkg::result_t res;
	logic                   res_req;
	logic                   res_ack;

	shift_alu_pkg::cmd_t    pending[$];  // Commands still to send
	int                     delays[$];   // Ack delay per result
	shift_alu_pkg::result_t expected[$]; // In send order
	shift_alu_pkg::tag_t    next_tag;
	int                     accepted    = 0;
	int                     word_errs   = 0;
	int                     tag_errs    = 0;
	int                     carry_errs  = 0;
	int                     other_errs  = 0;
	int                     assert_errs = 0;

	shift_alu_top shift_alu_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display(">>> FAIL");
		$finish;
	end

	// Result rules, shifts built from a 32-bit window
	function automatic shift_alu_pkg::result_t reference_result(input shift_alu_pkg::cmd_t c);
		shift_alu_pkg::result_t r;
		logic [31:0]            wide;
		r       = '0;
		case (c.op)
			shift_alu_pkg::OP_ADD: {r.carry, r.value} = {1'b0, c.a} + {1'b0, c.b};
			shift_alu_pkg::OP_SUB: {r.carry, r.value} = {1'b0, c.a} + {1'b0, ~c.b} + 17'd1;
			shift_alu_pkg::OP_SHR: begin
				case (c.kind)
					shift_alu_pkg::SH_LOGIC:  wide = {16'h0000, c.a} >> c.shamt;
					shift_alu_pkg::SH_ARITH:  wide = {{16{c.a[15]}}, c.a} >> c.shamt;
					shift_alu_pkg::SH_DOUBLE: wide = {c.b, c.a} >> c.shamt;
					default:                  wide = {c.a, c.a} >> c.shamt; // Rotate
				endcase
				r.value = wide[15:0];
			end
			default: begin
				case (c.kind)
					shift_alu_pkg::SH_DOUBLE: wide = {c.a, c.b} << c.shamt;
					shift_alu_pkg::SH_CYCLIC: wide = {c.a, c.a} << c.shamt;
					default:                  wide = {c.a, 16'h0000} << c.shamt; // Zero fill
				endcase
				r.value = wide[31:16];
			end
		endcase
		return r;
	endfunction

	task automatic check_word(input string name, input shift_alu_pkg::word_t got,
			input shift_alu_pkg::word_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			word_errs++;
		end
	endtask

	task automatic check_tag(input string name, input shift_alu_pkg::tag_t got,
			input shift_alu_pkg::tag_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			tag_errs++;
		end
	endtask

	task automatic check_carry(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			carry_errs++;
		end
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		expected.delete();
		next_tag = '0; // DUT tag restarts too
	endtask

	// Command handshake, master side
	task automatic send_cmd(input shift_alu_pkg::cmd_t c);
		shift_alu_pkg::result_t r;
		r     = reference_result(c);
		r.tag = next_tag;
		next_tag++; // Wraps at 16
		expected.push_back(r);
		@(posedge clk);
		cmd     <= c;
		cmd_req <= 1'b1;
		do @(posedge clk); while (!cmd_ack);
		accepted++;
		cmd_req <= 1'b0;
		do @(posedge clk); while (cmd_ack); // Ack low before the next request
	endtask

	// Result handshake, slave side
	task automatic receive_result(input int delay);
		shift_alu_pkg::result_t got;
		shift_alu_pkg::result_t exp;
		do @(posedge clk); while (!res_req);
		got = res;
		repeat (delay) @(posedge clk);
		res_ack <= 1'b1;
		do @(posedge clk); while (res_req);
		res_ack <= 1'b0;
		if (expected.size() == 0) begin
			$display("A result with tag %h arrived with no command outstanding", got.tag);
			other_errs++;
		end else begin
			exp = expected.pop_front();
			check_tag("res.tag", got.tag, exp.tag);
			check_word("res.value", got.value, exp.value);
			check_carry("res.carry", got.carry, exp.carry);
		end
	endtask

	task automatic queue_cmd(input shift_alu_pkg::alu_op_t op,
			input shift_alu_pkg::shift_kind_t kind, input shift_alu_pkg::shamt_t shamt,
			input shift_alu_pkg::word_t a, input shift_alu_pkg::word_t b);
		pending.push_back(shift_alu_pkg::cmd_t'{op, kind, shamt, a, b});
		delays.push_back(1);
	endtask

	function automatic shift_alu_pkg::cmd_t random_cmd();
		shift_alu_pkg::cmd_t c;
		c.op    = shift_alu_pkg::alu_op_t'($urandom_range(0, 3));
		c.kind  = shift_alu_pkg::shift_kind_t'($urandom_range(0, 3));
		c.shamt = shift_alu_pkg::shamt_t'($urandom);
		c.a     = shift_alu_pkg::word_t'($urandom);
		c.b     = shift_alu_pkg::word_t'($urandom);
		return c;
	endfunction

	// Sender and receiver run side by side
	task automatic run_batch();
		int n;
		n = pending.size();
		fork
			while (pending.size() > 0)
				send_cmd(pending.pop_front());
			repeat (n) receive_result(delays.pop_front());
		join
	endtask

	task automatic test_add_sub();
		shift_alu_pkg::word_t pairs [5][2] = '{'{16'h0000, 16'h0000}, '{16'hffff, 16'h0001},
			'{16'hffff, 16'hffff}, '{16'h0003, 16'h0005}, '{16'h8000, 16'h8000}};
		for (int i = 0; i < 5; i++) begin
			queue_cmd(shift_alu_pkg::OP_ADD, shift_alu_pkg::SH_LOGIC, 0, pairs[i][0], pairs[i][1]);
			queue_cmd(shift_alu_pkg::OP_SUB, shift_alu_pkg::SH_LOGIC, 0, pairs[i][0], pairs[i][1]);
		end
		run_batch();
	endtask

	task automatic test_shifts(input logic left);
		int amounts [4] = '{0, 1, 7, 15};
		for (int k = 0; k < 4; k++)
			for (int s = 0; s < 4; s++)
				queue_cmd(left ? shift_alu_pkg::OP_SHL : shift_alu_pkg::OP_SHR,
					shift_alu_pkg::shift_kind_t'(k), amounts[s], 16'hb3c5, 16'h6e19);
		run_batch();
	endtask

	// FIFO plus the exec unit hold five, the sixth must stall
	task automatic test_back_pressure();
		apply_reset();
		for (int i = 0; i < 6; i++)
			pending.push_back(random_cmd());
		accepted = 0;
		fork
			while (pending.size() > 0)
				send_cmd(pending.pop_front());
			begin
				repeat (40) @(posedge clk); // Result port held off
				if (accepted != shift_alu_pkg::FIFO_DEPTH + 1) begin
					$display("Back-pressure broken: %0d commands accepted while stalled", accepted);
					other_errs++;
				end
				repeat (6) receive_result(5 + $urandom_range(0, 3)); // Slow drain
			end
		join
	endtask

	task automatic test_random();
		for (int i = 0; i < 200; i++) begin
			pending.push_back(random_cmd());
			delays.push_back($urandom_range(0, 6));
		end
		run_batch();
	endtask

	initial begin
		void'($urandom(32'hd02f));
		reset    = 1'b1;
		cmd      = '0;
		cmd_req  = 1'b0;
		res_ack  = 1'b0;
		next_tag = '0;
		apply_reset();
		test_add_sub();
		test_shifts(1'b0);
		test_shifts(1'b1);
		test_back_pressure();
		test_random();
		repeat (20) @(posedge clk); // Every command answered, port stays quiet
		if (res_req) begin
			$display("A result with tag %h arrived after every command was answered", res.tag);
			other_errs++;
		end
		assert_errs = shift_alu_top_inst.shift_alu_assertions_inst.fail_count;
		$display("Errors: %0d value, %0d tag, %0d carry, %0d other, %0d assertion",
			word_errs, tag_errs, carry_errs, other_errs, assert_errs);
		if (word_errs + tag_errs + carry_errs + other_errs + assert_errs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- shift_alu.f
rtl/shift_alu_pkg.sv
rtl/cla_adder.sv
rtl/poly_shifter.sv
rtl/cmd_fifo.sv
rtl/cmd_intake.sv
rtl/exec_unit.sv
rtl/shift_alu_top.sv
verif/shift_alu_assertions.sv
verif/shift_alu_tb.sv
